//--- et_pkg.sv
package et_pkg;

    // Receiver geometry
    localparam int LANES      = 4;
    localparam int ERR_W      = 8;

    // Capture window, oldest sample at the lowest positions
    localparam int HIST_DEPTH = 3;
    localparam int WIN_POS    = LANES * HIST_DEPTH;
    localparam int SEL_W      = $clog2(WIN_POS);

    // Capture memory
    localparam int MEM_DEPTH  = 16;
    localparam int ADDR_W     = $clog2(MEM_DEPTH);
    localparam int CNT_W      = $clog2(MEM_DEPTH + 1);

    // Window slot of the flagged sample
    localparam int SLOT_FLAG  = 1;
    // History age of the flagged sample once its window is complete
    localparam int FLAG_AGE   = HIST_DEPTH - 1 - SLOT_FLAG;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        ACK,
        RELEASE
    } rd_state_e;

    // Position p holds slot p / LANES and lane p % LANES
    function automatic int win_pos(int slot, int lane);
        return slot * LANES + lane;
    endfunction

endpackage

//--- et_intf.sv
`timescale 1ns/1ns

// Flattened window from the history to the capture memory
interface err_window_intf import et_pkg::*; ();
    logic [WIN_POS-1:0]      win_bits;
    logic signed [ERR_W-1:0] win_err [WIN_POS];
    logic [1:0]              win_sd  [WIN_POS];
    logic [WIN_POS-1:0]      win_prbs;
    logic                    trigger;

    modport hist (output win_bits, win_err, win_sd, win_prbs, trigger);
    modport core (input win_bits, win_err, win_sd, win_prbs, trigger);
endinterface

// Single-position read of the capture memory, data one cycle after rd_en
interface capture_rd_intf import et_pkg::*; ();
    logic                    rd_en;
    logic [ADDR_W-1:0]       rd_addr;
    logic [SEL_W-1:0]        rd_sel;
    logic                    rd_bit;
    logic signed [ERR_W-1:0] rd_err;
    logic [1:0]              rd_sd;
    logic                    rd_prbs;

    modport reader (output rd_en, rd_addr, rd_sel, input rd_bit, rd_err, rd_sd, rd_prbs);
    modport core (input rd_en, rd_addr, rd_sel, output rd_bit, rd_err, rd_sd, rd_prbs);
endinterface

//--- sample_history.sv
`timescale 1ns/1ns

module sample_history import et_pkg::*; (
    input  logic                    clk,
    input  logic                    rstb,
    input  logic [LANES-1:0]        prbs_flags_i,
    input  logic signed [ERR_W-1:0] est_error_i   [LANES],
    input  logic                    sliced_bits_i [LANES],
    input  logic [1:0]              sd_flags_i    [LANES],
    err_window_intf.hist            win
);

    // Age 0 is the newest sample
    logic [LANES-1:0]        hist_bits [HIST_DEPTH];
    logic signed [ERR_W-1:0] hist_err  [HIST_DEPTH][LANES];
    logic [1:0]              hist_sd   [HIST_DEPTH][LANES];
    logic [LANES-1:0]        hist_prbs [HIST_DEPTH];
    logic                    trigger_q;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int a = 0; a < HIST_DEPTH; a++) begin
                hist_bits[a] <= '0;
                hist_prbs[a] <= '0;
                for (int l = 0; l < LANES; l++) begin
                    hist_err[a][l] <= '0;
                    hist_sd[a][l]  <= '0;
                end
            end
            trigger_q <= 1'b0;
        end else begin
            for (int l = 0; l < LANES; l++) begin
                hist_bits[0][l] <= sliced_bits_i[l];
                hist_err[0][l]  <= est_error_i[l];
                hist_sd[0][l]   <= sd_flags_i[l];
            end
            hist_prbs[0] <= prbs_flags_i;
            for (int a = 1; a < HIST_DEPTH; a++) begin
                hist_bits[a] <= hist_bits[a-1];
                hist_err[a]  <= hist_err[a-1];
                hist_sd[a]   <= hist_sd[a-1];
                hist_prbs[a] <= hist_prbs[a-1];
            end
            // Fires while the flagged sample sits in the middle slot
            trigger_q <= |hist_prbs[FLAG_AGE-1];
        end
    end

    // Window slot s is history age HIST_DEPTH-1-s
    for (genvar s = 0; s < HIST_DEPTH; s++) begin : g_slot
        for (genvar l = 0; l < LANES; l++) begin : g_lane
            assign win.win_bits[win_pos(s, l)] = hist_bits[HIST_DEPTH-1-s][l];
            assign win.win_err[win_pos(s, l)]  = hist_err[HIST_DEPTH-1-s][l];
            assign win.win_sd[win_pos(s, l)]   = hist_sd[HIST_DEPTH-1-s][l];
            assign win.win_prbs[win_pos(s, l)] = hist_prbs[HIST_DEPTH-1-s][l];
        end
    end

    assign win.trigger = trigger_q;

    a_trigger_known: assert property (@(posedge clk) disable iff (!rstb)
        !$isunknown(win.trigger));

endmodule

//--- error_tracker_core.sv
`timescale 1ns/1ns

module error_tracker_core import et_pkg::*; (
    input  logic             clk,
    input  logic             rstb,
    err_window_intf.core     win,
    capture_rd_intf.core     rd,
    output logic [CNT_W-1:0] capture_count_o,
    output logic             overflow_o
);

    logic [WIN_POS-1:0]      mem_bits [MEM_DEPTH];
    logic signed [ERR_W-1:0] mem_err  [MEM_DEPTH][WIN_POS];
    logic [1:0]              mem_sd   [MEM_DEPTH][WIN_POS];
    logic [WIN_POS-1:0]      mem_prbs [MEM_DEPTH];
    logic [ADDR_W-1:0]       wr_ptr;
    logic [CNT_W-1:0]        count;
    logic                    full;
    logic                    wr_en;
    logic                    sel_ok;

    assign full   = (count == CNT_W'(MEM_DEPTH));
    // Triggers are dropped once every entry is used
    assign wr_en  = win.trigger && !full;
    assign sel_ok = (rd.rd_sel < SEL_W'(WIN_POS));

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            wr_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
            count  <= count + 1'b1;
            // Last free entry is being written
            if (count == CNT_W'(MEM_DEPTH - 1)) begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_bits[wr_ptr] <= win.win_bits;
            mem_err[wr_ptr]  <= win.win_err;
            mem_sd[wr_ptr]   <= win.win_sd;
            mem_prbs[wr_ptr] <= win.win_prbs;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            if (sel_ok) begin
                rd.rd_bit  <= mem_bits[rd.rd_addr][rd.rd_sel];
                rd.rd_err  <= mem_err[rd.rd_addr][rd.rd_sel];
                rd.rd_sd   <= mem_sd[rd.rd_addr][rd.rd_sel];
                rd.rd_prbs <= mem_prbs[rd.rd_addr][rd.rd_sel];
            end else begin
                // Positions past the window read as zero
                rd.rd_bit  <= 1'b0;
                rd.rd_err  <= '0;
                rd.rd_sd   <= '0;
                rd.rd_prbs <= 1'b0;
            end
        end
    end

    assign capture_count_o = count;

    a_count_bound: assert property (@(posedge clk) disable iff (!rstb)
        count <= CNT_W'(MEM_DEPTH));

    // Overflow is sticky and freezes the memory contents
    a_no_write_after_overflow: assert property (@(posedge clk) disable iff (!rstb)
        overflow_o |=> overflow_o && $stable(count) && $stable(wr_ptr));

endmodule

//--- debug_read_port.sv
`timescale 1ns/1ns

module debug_read_port import et_pkg::*; (
    input  logic                    clk,
    input  logic                    rstb,
    input  logic                    rd_req_i,
    input  logic [ADDR_W-1:0]       rd_addr_i,
    input  logic [SEL_W-1:0]        rd_sel_i,
    output logic                    rd_ack_o,
    output logic                    rd_bit_o,
    output logic signed [ERR_W-1:0] rd_err_o,
    output logic [1:0]              rd_sd_o,
    output logic                    rd_prbs_o,
    capture_rd_intf.reader          rd
);

    rd_state_e         state;
    logic              rd_en_q;
    logic [ADDR_W-1:0] addr_q;
    logic [SEL_W-1:0]  sel_q;
    logic              take_data;

    // Core data is valid in READ once the enable pulse has passed
    assign take_data = (state == READ) && !rd_en_q;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state    <= IDLE;
            rd_en_q  <= 1'b0;
            rd_ack_o <= 1'b0;
        end else begin
            rd_en_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (rd_req_i) begin
                        rd_en_q <= 1'b1;
                        state   <= READ;
                    end
                end
                READ: begin
                    if (take_data) begin
                        rd_ack_o <= 1'b1;
                        state    <= ACK;
                    end
                end
                ACK: begin
                    if (!rd_req_i) begin
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    rd_ack_o <= 1'b0;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields held for the core, returned fields held for the host
    always_ff @(posedge clk) begin
        if (state == IDLE && rd_req_i) begin
            addr_q <= rd_addr_i;
            sel_q  <= rd_sel_i;
        end
        if (take_data) begin
            rd_bit_o  <= rd.rd_bit;
            rd_err_o  <= rd.rd_err;
            rd_sd_o   <= rd.rd_sd;
            rd_prbs_o <= rd.rd_prbs;
        end
    end

    assign rd.rd_en   = rd_en_q;
    assign rd.rd_addr = addr_q;
    assign rd.rd_sel  = sel_q;

    // Req must have been high at the edge that raised ack
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstb)
        $rose(rd_ack_o) |-> $past(rd_req_i));

endmodule

//--- error_tracker.sv
`timescale 1ns/1ns

module error_tracker import et_pkg::*; (
    input  logic                    clk,
    input  logic                    rstb,

    // Per-lane receiver outputs
    input  logic [LANES-1:0]        prbs_flags_i,
    input  logic signed [ERR_W-1:0] est_error_i   [LANES],
    input  logic                    sliced_bits_i [LANES],
    input  logic [1:0]              sd_flags_i    [LANES],

    // Debug read handshake
    input  logic                    rd_req_i,
    input  logic [ADDR_W-1:0]       rd_addr_i,
    input  logic [SEL_W-1:0]        rd_sel_i,
    output logic                    rd_ack_o,
    output logic                    rd_bit_o,
    output logic signed [ERR_W-1:0] rd_err_o,
    output logic [1:0]              rd_sd_o,
    output logic                    rd_prbs_o,

    // Capture status
    output logic [CNT_W-1:0]        capture_count_o,
    output logic                    overflow_o
);

    err_window_intf win_if ();
    capture_rd_intf rd_if ();

    sample_history sample_history_inst (
        .clk           (clk),
        .rstb          (rstb),
        .prbs_flags_i  (prbs_flags_i),
        .est_error_i   (est_error_i),
        .sliced_bits_i (sliced_bits_i),
        .sd_flags_i    (sd_flags_i),
        .win           (win_if.hist)
    );

    error_tracker_core error_tracker_core_inst (
        .clk             (clk),
        .rstb            (rstb),
        .win             (win_if.core),
        .rd              (rd_if.core),
        .capture_count_o (capture_count_o),
        .overflow_o      (overflow_o)
    );

    debug_read_port debug_read_port_inst (
        .clk       (clk),
        .rstb      (rstb),
        .rd_req_i  (rd_req_i),
        .rd_addr_i (rd_addr_i),
        .rd_sel_i  (rd_sel_i),
        .rd_ack_o  (rd_ack_o),
        .rd_bit_o  (rd_bit_o),
        .rd_err_o  (rd_err_o),
        .rd_sd_o   (rd_sd_o),
        .rd_prbs_o (rd_prbs_o),
        .rd        (rd_if.reader)
    );

endmodule

//--- tb_error_tracker.sv
`timescale 1ns/1ns

module tb_error_tracker import et_pkg::*; ();

    // Far more samples than the whole run drives
    localparam int LOG_LEN        = 512;
    // About 60 reads of 6 cycles plus 100 samples, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int ACK_LIMIT      = 16;

    logic                    clk;
    logic                    rstb;
    logic [LANES-1:0]        prbs_flags;
    logic signed [ERR_W-1:0] est_error   [LANES];
    logic                    sliced_bits [LANES];
    logic [1:0]              sd_flags    [LANES];
    logic                    rd_req;
    logic [ADDR_W-1:0]       rd_addr;
    logic [SEL_W-1:0]        rd_sel;
    logic                    rd_ack;
    logic                    rd_bit;
    logic signed [ERR_W-1:0] rd_err;
    logic [1:0]              rd_sd;
    logic                    rd_prbs;
    logic [CNT_W-1:0]        capture_count;
    logic                    overflow;

    // Every driven sample, in drive order
    logic [LANES-1:0]        log_bits [LOG_LEN];
    logic signed [ERR_W-1:0] log_err  [LOG_LEN][LANES];
    logic [1:0]              log_sd   [LOG_LEN][LANES];
    logic [LANES-1:0]        log_prbs [LOG_LEN];
    int                      n_samples;
    // Sample index of each flag that should be stored, one per entry
    int                      cap_idx [$];
    int                      exp_count;
    logic [31:0]             lfsr_state;
    int                      cycle_count = 0;

    error_tracker error_tracker_inst (
        .clk             (clk),
        .rstb            (rstb),
        .prbs_flags_i    (prbs_flags),
        .est_error_i     (est_error),
        .sliced_bits_i   (sliced_bits),
        .sd_flags_i      (sd_flags),
        .rd_req_i        (rd_req),
        .rd_addr_i       (rd_addr),
        .rd_sel_i        (rd_sel),
        .rd_ack_o        (rd_ack),
        .rd_bit_o        (rd_bit),
        .rd_err_o        (rd_err),
        .rd_sd_o         (rd_sd),
        .rd_prbs_o       (rd_prbs),
        .capture_count_o (capture_count),
        .overflow_o      (overflow)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout, run still going after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string test_name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                test_name, expected, actual));
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic drive_sample(input logic [LANES-1:0] flags);
        @(negedge clk);
        if (n_samples == LOG_LEN) begin
            abort_run("Sample log ran out of space");
        end
        for (int l = 0; l < LANES; l++) begin
            sliced_bits[l] = 1'(take_bits(1));
            est_error[l]   = ERR_W'(take_bits(ERR_W));
            sd_flags[l]    = 2'(take_bits(2));
            log_bits[n_samples][l] = sliced_bits[l];
            log_err[n_samples][l]  = est_error[l];
            log_sd[n_samples][l]   = sd_flags[l];
        end
        prbs_flags = flags;
        log_prbs[n_samples] = flags;
        // A flag is stored only while the memory has room
        if (flags != '0 && exp_count < MEM_DEPTH) begin
            cap_idx.push_back(n_samples);
            exp_count++;
        end
        n_samples++;
    endtask

    task automatic wait_for_count(input int target);
        int waited;
        waited = 0;
        while (int'(capture_count) < target) begin
            if (waited == 8) begin
                abort_run($sformatf("Capture count stuck at %0d while waiting for %0d",
                                    capture_count, target));
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic read_pos(input int entry, input int p, output logic got_bit,
                            output logic signed [ERR_W-1:0] got_err,
                            output logic [1:0] got_sd, output logic got_prbs);
        int waited;
        @(negedge clk);
        rd_addr = ADDR_W'(entry);
        rd_sel  = SEL_W'(p);
        rd_req  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!rd_ack) begin
            waited++;
            if (waited == ACK_LIMIT) begin
                abort_run("Debug reader never raised ack");
            end
            @(negedge clk);
        end
        got_bit  = rd_bit;
        got_err  = rd_err;
        got_sd   = rd_sd;
        got_prbs = rd_prbs;
        rd_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (rd_ack) begin
            waited++;
            if (waited == ACK_LIMIT) begin
                abort_run("Debug reader kept ack high after req dropped");
            end
            @(negedge clk);
        end
    endtask

    // Position p is slot p / LANES, lane p % LANES; slot 0 is the sample before the flag
    task automatic compare_fields(input string test_name, input int flag_idx, input int p,
                                  input logic got_bit, input logic signed [ERR_W-1:0] got_err,
                                  input logic [1:0] got_sd, input logic got_prbs);
        int    lane;
        int    idx;
        string tag;
        lane = p % LANES;
        idx  = flag_idx - 1 + p / LANES;
        tag  = $sformatf("%s pos %0d", test_name, p);
        check({tag, " bit"}, 32'(log_bits[idx][lane]), 32'(got_bit));
        check({tag, " err"}, 32'(log_err[idx][lane]), 32'(got_err));
        check({tag, " sd"}, 32'(log_sd[idx][lane]), 32'(got_sd));
        check({tag, " prbs"}, 32'(log_prbs[idx][lane]), 32'(got_prbs));
    endtask

    task automatic check_entry(input string test_name, input int entry);
        logic                    got_bit;
        logic signed [ERR_W-1:0] got_err;
        logic [1:0]              got_sd;
        logic                    got_prbs;
        for (int p = 0; p < WIN_POS; p++) begin
            read_pos(entry, p, got_bit, got_err, got_sd, got_prbs);
            compare_fields($sformatf("%s entry %0d", test_name, entry), cap_idx[entry], p,
                           got_bit, got_err, got_sd, got_prbs);
        end
    endtask

    task automatic test_reset();
        check("reset count", 0, 32'(capture_count));
        check("reset overflow", 0, 32'(overflow));
        check("reset ack", 0, 32'(rd_ack));
    endtask

    task automatic test_single_flag();
        repeat (2) drive_sample('0);
        drive_sample(LANES'(1) << 2);
        repeat (3) drive_sample('0);
        wait_for_count(1);
        check("single_flag count", 1, 32'(capture_count));
        check_entry("single_flag", 0);
    endtask

    task automatic test_back_to_back();
        drive_sample('0);
        drive_sample(LANES'(1));
        drive_sample(LANES'(10));
        repeat (3) drive_sample('0);
        wait_for_count(3);
        check("back_to_back count", 3, 32'(capture_count));
        check_entry("back_to_back", 1);
        check_entry("back_to_back", 2);
    endtask

    task automatic test_handshake();
        @(negedge clk);
        rd_addr = '0;
        rd_sel  = SEL_W'(5);
        rd_req  = 1'b1;
        @(negedge clk);
        check("handshake ack one edge after req", 0, 32'(rd_ack));
        @(negedge clk);
        check("handshake ack two edges after req", 0, 32'(rd_ack));
        @(negedge clk);
        check("handshake ack three edges after req", 1, 32'(rd_ack));
        // Host stalls with req held
        repeat (5) begin
            @(negedge clk);
            check("handshake ack held", 1, 32'(rd_ack));
        end
        compare_fields("handshake entry 0", cap_idx[0], 5, rd_bit, rd_err, rd_sd, rd_prbs);
        rd_req = 1'b0;
        @(negedge clk);
        check("handshake ack at req drop edge", 1, 32'(rd_ack));
        @(negedge clk);
        check("handshake ack one edge after drop", 0, 32'(rd_ack));
    endtask

    task automatic test_overflow();
        check("overflow before full", 0, 32'(overflow));
        while (exp_count < MEM_DEPTH) begin
            drive_sample('0);
            drive_sample(LANES'(1) << (exp_count % LANES));
        end
        repeat (3) drive_sample('0);
        wait_for_count(MEM_DEPTH);
        check("overflow flag when full", 1, 32'(overflow));
        check("overflow count when full", MEM_DEPTH, 32'(capture_count));
        // This flag must be dropped
        drive_sample('0);
        drive_sample('1);
        repeat (3) drive_sample('0);
        check("overflow count after extra flag", MEM_DEPTH, 32'(capture_count));
        check("overflow flag after extra flag", 1, 32'(overflow));
        check_entry("overflow", 0);
        check_entry("overflow", MEM_DEPTH - 1);
    endtask

    initial begin
        rstb       = 1'b0;
        prbs_flags = '0;
        rd_req     = 1'b0;
        rd_addr    = '0;
        rd_sel     = '0;
        for (int l = 0; l < LANES; l++) begin
            est_error[l]   = '0;
            sliced_bits[l] = 1'b0;
            sd_flags[l]    = '0;
        end
        lfsr_state = 32'hbe68_b340;
        n_samples  = 0;
        exp_count  = 0;
        repeat (8) @(negedge clk);
        rstb = 1'b1;

        test_reset();
        test_single_flag();
        test_back_to_back();
        test_handshake();
        test_overflow();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- files.f
et_pkg.sv
et_intf.sv
sample_history.sv
error_tracker_core.sv
debug_read_port.sv
error_tracker.sv
tb_error_tracker.sv

//--- Makefile
TB_TOP = tb_error_tracker

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module error_tracker -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f files.f -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
